/* verticalStretch.f */
+incdir+logic
logic/stretchPkg.sv
logic/blendIf.sv
logic/rowDecoder.sv
logic/lineCache.sv
logic/blendExecute.sv
logic/blendResult.sv
logic/verticalStretch.sv
tests/stretchTb.sv

/* run.sh */
#!/bin/sh
# Builds the stretch filter testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -f sim.log &&
verilator --binary --timing --assert --top-module stretchTb -f verticalStretch.f &&
./obj_dir/VstretchTb > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "Regression passed" sim.log || exit 1

/* tests/stretchTb.sv */
// Source image, row responder, output monitor, reference model and directed tests
// for the vertical stretch filter

`timescale 1ns/1ns
`include "stretch_config.svh"

module stretchTb;

    localparam int timeoutCycles = 5000;
    localparam int imageRows = 64;

    logic scalerClock = 1'b0;
    logic reset;
    stretchPkg::scaleT vShrinkFactor;
    logic rowRequest;
    stretchPkg::rowT requestedRow;
    logic busy;
    logic upstreamRowRequest;
    stretchPkg::rowT upstreamRequestRow;
    logic upstreamPixelValid;
    stretchPkg::rgb565T upstreamPixelData;
    logic downstreamPixelValid;
    stretchPkg::rgb565T downstreamPixelData;
    logic downstreamFull;
    logic pressureOn;

    stretchPkg::rgb565T sourceImage [imageRows][`STRETCH_LINE_WIDTH];
    stretchPkg::rgb565T received [$];
    int fetched [$];
    int expectedFetches [$];
    int failCount = 0;

    // Model copies of the decoder's cache tags start empty after reset
    int modelTagA = 2047;
    int modelTagB = 2047;
    bit modelBOlder = 1'b0;

    verticalStretch UUT (
        .scalerClock(scalerClock), .reset(reset), .vShrinkFactor(vShrinkFactor),
        .rowRequest(rowRequest), .requestedRow(requestedRow), .busy(busy),
        .upstreamRowRequest(upstreamRowRequest), .upstreamRequestRow(upstreamRequestRow),
        .upstreamPixelValid(upstreamPixelValid), .upstreamPixelData(upstreamPixelData),
        .downstreamPixelValid(downstreamPixelValid), .downstreamPixelData(downstreamPixelData),
        .downstreamFull(downstreamFull)
    );

    always #50 scalerClock = ~scalerClock;

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            failCount++;
            $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
            $display("Regression failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic abortRun(string reason);
        $display("Regression failed");
        $display("%s", reason);
        $fatal(1, "run aborted");
    endtask

    // Each component is upper times its coefficient plus lower times its coefficient, over 64
    function automatic stretchPkg::rgb565T blendPixel(stretchPkg::rgb565T upper,
                                                      stretchPkg::rgb565T lower, int fraction);
        int upperCoeff;
        int lowerCoeff;
        int red;
        int green;
        int blue;
        upperCoeff = (fraction == 0) ? 64 : 63 - fraction;
        lowerCoeff = (fraction == 0) ? 0 : fraction;
        red = (int'(upper[15:11]) * upperCoeff + int'(lower[15:11]) * lowerCoeff) >> 6;
        green = (int'(upper[10:5]) * upperCoeff + int'(lower[10:5]) * lowerCoeff) >> 6;
        blue = (int'(upper[4:0]) * upperCoeff + int'(lower[4:0]) * lowerCoeff) >> 6;
        return {red[4:0], green[5:0], blue[4:0]};
    endfunction

    function automatic bit isCached(int row);
        return (row == modelTagA) || (row == modelTagB);
    endfunction

    // Predicts the fetches in order with the upper row first and updates the model tags
    task automatic predictFetches(int upperRow, int lowerRow);
        int missRow;
        int otherRow;
        bit replaceB;
        expectedFetches.delete();
        while (!(isCached(upperRow) && isCached(lowerRow))) begin
            missRow = isCached(upperRow) ? lowerRow : upperRow;
            otherRow = isCached(upperRow) ? upperRow : lowerRow;
            // The older cache goes unless it holds the other needed row
            replaceB = modelBOlder;
            if ((replaceB ? modelTagB : modelTagA) == otherRow) begin
                replaceB = !replaceB;
            end
            if (replaceB) begin
                modelTagB = missRow;
                modelBOlder = 1'b0;
            end else begin
                modelTagA = missRow;
                modelBOlder = 1'b1;
            end
            expectedFetches.push_back(missRow);
        end
    endtask

    task automatic applyFactor(int factor);
        @(posedge scalerClock);
        #5 vShrinkFactor = stretchPkg::scaleT'(factor);
    endtask

    task automatic requestRow(int row);
        int factor;
        int coord;
        int upperRow;
        int lowerRow;
        int fraction;
        factor = int'(vShrinkFactor);
        coord = row * factor + factor / 2 - ((factor >= 64) ? 32 : 0);
        upperRow = coord >> 6;
        fraction = coord % 64;
        lowerRow = (fraction == 0) ? upperRow : upperRow + 1;
        if (lowerRow >= imageRows) begin
            abortRun("A test row maps outside the source image");
        end
        predictFetches(upperRow, lowerRow);
        received.delete();
        fetched.delete();
        @(posedge scalerClock);
        #5 rowRequest = 1'b1;
        requestedRow = stretchPkg::rowT'(row);
        @(posedge scalerClock);
        #5 rowRequest = 1'b0;
        checkValue("busy", 1, 32'(busy));
        do begin
            @(negedge scalerClock);
        end while (busy);
        @(posedge scalerClock);
        #5;
        checkValue("fetch count", expectedFetches.size(), fetched.size());
        foreach (expectedFetches[i]) begin
            checkValue("upstreamRequestRow", expectedFetches[i], fetched[i]);
        end
        checkValue("pixel count", `STRETCH_LINE_WIDTH, received.size());
        foreach (received[column]) begin
            checkValue("downstreamPixelData", 32'(blendPixel(sourceImage[upperRow][column],
                sourceImage[lowerRow][column], fraction)), 32'(received[column]));
        end
    endtask

    // Answers each fetch with the whole row and random gaps between pixels
    always begin
        int row;
        @(negedge scalerClock);
        if (upstreamRowRequest) begin
            row = int'(upstreamRequestRow);
            fetched.push_back(row);
            if (row >= imageRows) begin
                abortRun("The DUT fetched a row outside the source image");
            end
            for (int column = 0; column < `STRETCH_LINE_WIDTH; column++) begin
                repeat ($urandom_range(2, 0)) begin
                    @(posedge scalerClock);
                    #5 upstreamPixelValid = 1'b0;
                end
                @(posedge scalerClock);
                #5 upstreamPixelValid = 1'b1;
                upstreamPixelData = sourceImage[row][column];
            end
            @(posedge scalerClock);
            #5 upstreamPixelValid = 1'b0;
        end
    end

    always @(negedge scalerClock) begin
        if (downstreamPixelValid && downstreamFull) begin
            abortRun("A downstream pixel was issued while the downstream side was full");
        end else if (downstreamPixelValid) begin
            received.push_back(downstreamPixelData);
        end
    end

    always @(posedge scalerClock) begin
        #5;
        if (pressureOn) begin
            downstreamFull = ($urandom_range(1, 0) == 1);
        end else begin
            downstreamFull = 1'b0;
        end
    end

    initial begin
        int cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge scalerClock);
            cycleCount++;
        end
        $display("Regression failed");
        $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
        $fatal(1, "simulation timeout");
    end

    task automatic idleAfterReset();
        repeat (4) begin
            @(posedge scalerClock);
            #5;
            checkValue("busy", 0, 32'(busy));
            checkValue("upstreamRowRequest", 0, 32'(upstreamRowRequest));
            checkValue("downstreamPixelValid", 0, 32'(downstreamPixelValid));
        end
    endtask

    task automatic unityScale();
        applyFactor(64);
        requestRow(5);
    endtask

    task automatic fractionalBlend();
        applyFactor(40);
        for (int row = 0; row < 4; row++) begin
            requestRow(row);
        end
    endtask

    // Mixes overlapping, reversed and shrinking requests so both caches get replaced
    // and an older cache that holds the other needed row is kept
    task automatic cacheReuse();
        requestRow(3);
        requestRow(0);
        requestRow(1);
        applyFactor(96);
        requestRow(2);
        requestRow(3);
        requestRow(1);
        applyFactor(24);
        requestRow(6);
        requestRow(7);
        requestRow(3);
        requestRow(0);
        requestRow(3);
    endtask

    task automatic backPressure();
        pressureOn = 1'b1;
        applyFactor(40);
        requestRow(9);
        requestRow(10);
        applyFactor(64);
        requestRow(2);
        applyFactor(96);
        requestRow(5);
        pressureOn = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h449b));
        for (int row = 0; row < imageRows; row++) begin
            for (int column = 0; column < `STRETCH_LINE_WIDTH; column++) begin
                sourceImage[row][column] = stretchPkg::rgb565T'($urandom());
            end
        end
        reset = 1'b1;
        vShrinkFactor = stretchPkg::scaleT'(64);
        rowRequest = 1'b0;
        requestedRow = '0;
        upstreamPixelValid = 1'b0;
        upstreamPixelData = '0;
        downstreamFull = 1'b0;
        pressureOn = 1'b0;
        repeat (8) @(posedge scalerClock);
        #5 reset = 1'b0;
        idleAfterReset();
        unityScale();
        fractionalBlend();
        cacheReuse();
        backPressure();
        if (failCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* logic/verticalStretch.sv */
// Vertical stretch filter top level: row decoder, line cache and blend pipeline

`timescale 1ns/1ns

module verticalStretch (
    input logic scalerClock,
    input logic reset,
    input stretchPkg::scaleT vShrinkFactor,
    input logic rowRequest,
    input stretchPkg::rowT requestedRow,
    output logic busy,
    output logic upstreamRowRequest,
    output stretchPkg::rowT upstreamRequestRow,
    input logic upstreamPixelValid,
    input stretchPkg::rgb565T upstreamPixelData,
    output logic downstreamPixelValid,
    output stretchPkg::rgb565T downstreamPixelData,
    input logic downstreamFull
);

    logic fillStart;
    logic fillIntoB;
    logic fillDone;
    stretchPkg::columnT readColumn;
    stretchPkg::rgb565T readDataA;
    stretchPkg::rgb565T readDataB;

    blendIf blendBus ();

    rowDecoder decoder (
        .scalerClock(scalerClock), .reset(reset), .vShrinkFactor(vShrinkFactor),
        .rowRequest(rowRequest), .requestedRow(requestedRow), .busy(busy),
        .upstreamRowRequest(upstreamRowRequest), .upstreamRequestRow(upstreamRequestRow),
        .fillStart(fillStart), .fillIntoB(fillIntoB), .fillDone(fillDone),
        .blend(blendBus.decoder)
    );

    lineCache cache (
        .scalerClock(scalerClock), .reset(reset), .fillStart(fillStart),
        .fillIntoB(fillIntoB), .upstreamPixelValid(upstreamPixelValid),
        .upstreamPixelData(upstreamPixelData), .fillDone(fillDone),
        .readColumn(readColumn), .readDataA(readDataA), .readDataB(readDataB)
    );

    blendExecute execute (
        .scalerClock(scalerClock), .reset(reset), .blend(blendBus.execute),
        .readColumn(readColumn), .readDataA(readDataA), .readDataB(readDataB)
    );

    blendResult result (
        .scalerClock(scalerClock), .reset(reset), .blend(blendBus.result),
        .downstreamFull(downstreamFull), .downstreamPixelValid(downstreamPixelValid),
        .downstreamPixelData(downstreamPixelData)
    );

endmodule

/* logic/blendResult.sv */
// Weight summing, 5-6-5 packing, output hold under back-pressure and row completion

`timescale 1ns/1ns
`include "stretch_config.svh"

module blendResult (
    input logic scalerClock,
    input logic reset,
    blendIf.result blend,
    input logic downstreamFull,
    output logic downstreamPixelValid,
    output stretchPkg::rgb565T downstreamPixelData
);

    logic outValid;
    stretchPkg::columnT outCount;
    logic [5:0] redSum;
    logic [5:0] greenSum;
    logic [5:0] blueSum;

    // Coefficients add up to at most 1.0, so the sum fits and the top six bits are the color
    function automatic logic [5:0] componentSum(stretchPkg::weightT upper,
                                                stretchPkg::weightT lower);
        stretchPkg::weightT sum;
        sum = upper + lower;
        return sum[$bits(sum)-1:`STRETCH_FRACTION_BITS];
    endfunction

    assign redSum = componentSum(blend.upperRed, blend.lowerRed);
    assign greenSum = componentSum(blend.upperGreen, blend.lowerGreen);
    assign blueSum = componentSum(blend.upperBlue, blend.lowerBlue);

    assign blend.advance = !downstreamFull;
    assign downstreamPixelValid = outValid && !downstreamFull;
    assign blend.rowDone = downstreamPixelValid
        && (outCount == stretchPkg::columnT'(`STRETCH_LINE_WIDTH - 1));

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            outValid <= 1'b0;
            outCount <= '0;
        end else if (blend.advance) begin
            outValid <= blend.weightsValid;
            if (downstreamPixelValid) begin
                outCount <= blend.rowDone ? '0 : stretchPkg::columnT'(outCount + 1'b1);
            end
        end
    end

    always_ff @(posedge scalerClock) begin
        if (blend.advance) begin
            downstreamPixelData <= {redSum[4:0], greenSum, blueSum[4:0]};
        end
    end

endmodule

/* logic/blendExecute.sv */
// Column issue, cache read, color selection and weight multiplication

`timescale 1ns/1ns
`include "stretch_config.svh"

module blendExecute (
    input logic scalerClock,
    input logic reset,
    blendIf.execute blend,
    output stretchPkg::columnT readColumn,
    input stretchPkg::rgb565T readDataA,
    input stretchPkg::rgb565T readDataB
);

    stretchPkg::columnT column;
    logic active;
    logic readValid;
    logic selectValid;
    stretchPkg::rgb565T upperPixel;
    stretchPkg::rgb565T lowerPixel;
    stretchPkg::scaleT upperCoeff;
    stretchPkg::scaleT lowerCoeff;

    // While stalled, re-read the column already in the read stage so its data holds
    assign readColumn = blend.advance ? column : stretchPkg::columnT'(column - 1'b1);

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            column <= '0;
            active <= 1'b0;
            readValid <= 1'b0;
            selectValid <= 1'b0;
            blend.weightsValid <= 1'b0;
        end else if (blend.blendStart) begin
            column <= '0;
            active <= 1'b1;
        end else if (blend.advance) begin
            readValid <= active;
            selectValid <= readValid;
            blend.weightsValid <= selectValid;
            if (active) begin
                column <= column + 1'b1;
                active <= (column != stretchPkg::columnT'(`STRETCH_LINE_WIDTH - 1));
            end
        end
    end

    always_ff @(posedge scalerClock) begin
        if (blend.advance) begin
            upperPixel <= blend.upperInCacheA ? readDataA : readDataB;
            lowerPixel <= blend.upperInCacheA ? readDataB : readDataA;
            if (blend.blendFraction == '0) begin
                upperCoeff <= stretchPkg::scaleT'(1) << `STRETCH_FRACTION_BITS;
                lowerCoeff <= '0;
            end else begin
                upperCoeff <= {1'b0, ~blend.blendFraction};
                lowerCoeff <= {1'b0, blend.blendFraction};
            end
            // Red and blue are widened to six bits like green
            blend.upperRed <= stretchPkg::weightT'({1'b0, upperPixel[15:11]} * upperCoeff);
            blend.upperGreen <= stretchPkg::weightT'(upperPixel[10:5] * upperCoeff);
            blend.upperBlue <= stretchPkg::weightT'({1'b0, upperPixel[4:0]} * upperCoeff);
            blend.lowerRed <= stretchPkg::weightT'({1'b0, lowerPixel[15:11]} * lowerCoeff);
            blend.lowerGreen <= stretchPkg::weightT'(lowerPixel[10:5] * lowerCoeff);
            blend.lowerBlue <= stretchPkg::weightT'({1'b0, lowerPixel[4:0]} * lowerCoeff);
        end
    end

    // A new row starts only after the previous one has issued every column
    noStartWhileActive: assert property (@(posedge scalerClock) disable iff (reset)
        blend.blendStart |-> !active);

endmodule

/* logic/lineCache.sv */
// Two line caches with a fill column counter and a registered read port

`timescale 1ns/1ns
`include "stretch_config.svh"

module lineCache (
    input logic scalerClock,
    input logic reset,
    input logic fillStart,
    input logic fillIntoB,
    input logic upstreamPixelValid,
    input stretchPkg::rgb565T upstreamPixelData,
    output logic fillDone,
    input stretchPkg::columnT readColumn,
    output stretchPkg::rgb565T readDataA,
    output stretchPkg::rgb565T readDataB
);

    stretchPkg::rgb565T memoryA [`STRETCH_LINE_WIDTH];
    stretchPkg::rgb565T memoryB [`STRETCH_LINE_WIDTH];
    stretchPkg::columnT fillColumn;
    logic filling;
    logic fillTargetB;
    logic writeEnable;
    logic lastColumn;

    assign writeEnable = upstreamPixelValid && filling;
    assign lastColumn = (fillColumn == stretchPkg::columnT'(`STRETCH_LINE_WIDTH - 1));

    // Done in the same cycle as the final write
    assign fillDone = writeEnable && lastColumn;

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            filling <= 1'b0;
            fillColumn <= '0;
            fillTargetB <= 1'b0;
        end else if (fillStart) begin
            filling <= 1'b1;
            fillColumn <= '0;
            fillTargetB <= fillIntoB;
        end else if (writeEnable) begin
            if (lastColumn) begin
                filling <= 1'b0;
            end
            fillColumn <= fillColumn + 1'b1;
        end
    end

    always_ff @(posedge scalerClock) begin
        if (writeEnable && !fillTargetB) begin
            memoryA[fillColumn] <= upstreamPixelData;
        end
        if (writeEnable && fillTargetB) begin
            memoryB[fillColumn] <= upstreamPixelData;
        end
        readDataA <= memoryA[readColumn];
        readDataB <= memoryB[readColumn];
    end

    // The upstream side only sends pixels for a requested row
    pixelOnlyDuringFill: assert property (@(posedge scalerClock) disable iff (reset)
        upstreamPixelValid |-> filling);

endmodule

/* logic/rowDecoder.sv */
// Row request decoder: source row mapping, cache tags, row fetches and blend start

`timescale 1ns/1ns
`include "stretch_config.svh"

module rowDecoder (
    input logic scalerClock,
    input logic reset,
    input stretchPkg::scaleT vShrinkFactor,
    input logic rowRequest,
    input stretchPkg::rowT requestedRow,
    output logic busy,
    output logic upstreamRowRequest,
    output stretchPkg::rowT upstreamRequestRow,
    output logic fillStart,
    output logic fillIntoB,
    input logic fillDone,
    blendIf.decoder blend
);

    stretchPkg::decodeStateT state;
    stretchPkg::rowT latchedRow;
    stretchPkg::rowT upperRow;
    stretchPkg::rowT lowerRow;
    stretchPkg::fractionT fraction;
    stretchPkg::rowT tagA;
    stretchPkg::rowT tagB;
    logic bIsOlder;
    stretchPkg::coordT sourceCoord;
    logic upperHit;
    logic lowerHit;
    stretchPkg::rowT missRow;
    stretchPkg::rowT otherRow;
    logic victimB;

    // Scaled row, centered by half the factor, minus half a row when shrinking
    assign sourceCoord = stretchPkg::coordT'(latchedRow * vShrinkFactor)
        + stretchPkg::coordT'(vShrinkFactor >> 1)
        - (vShrinkFactor[`STRETCH_FRACTION_BITS]
            ? stretchPkg::coordT'(1) << (`STRETCH_FRACTION_BITS - 1)
            : stretchPkg::coordT'(0));

    assign upperHit = (tagA == upperRow) || (tagB == upperRow);
    assign lowerHit = (tagA == lowerRow) || (tagB == lowerRow);
    assign missRow = upperHit ? lowerRow : upperRow;
    assign otherRow = upperHit ? upperRow : lowerRow;

    // The older cache is the victim unless it holds the other row this request needs
    assign victimB = bIsOlder ? (tagB != otherRow) : (tagA == otherRow);

    assign busy = (state != stretchPkg::decodeIdle);
    assign upstreamRowRequest = (state == stretchPkg::decodeFetch);
    assign fillStart = (state == stretchPkg::decodeFetch);
    assign blend.blendFraction = fraction;

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            state <= stretchPkg::decodeIdle;
            tagA <= '1;
            tagB <= '1;
            bIsOlder <= 1'b0;
            blend.blendStart <= 1'b0;
            blend.upperInCacheA <= 1'b0;
        end else begin
            blend.blendStart <= 1'b0;
            case (state)
                stretchPkg::decodeIdle: begin
                    if (rowRequest) begin
                        latchedRow <= requestedRow;
                        state <= stretchPkg::decodeMap;
                    end
                end
                stretchPkg::decodeMap: begin
                    upperRow <= sourceCoord[$bits(sourceCoord)-1:`STRETCH_FRACTION_BITS];
                    fraction <= sourceCoord[`STRETCH_FRACTION_BITS-1:0];
                    lowerRow <= sourceCoord[$bits(sourceCoord)-1:`STRETCH_FRACTION_BITS]
                        + stretchPkg::rowT'(|sourceCoord[`STRETCH_FRACTION_BITS-1:0]);
                    state <= stretchPkg::decodeCheck;
                end
                stretchPkg::decodeCheck: begin
                    if (upperHit && lowerHit) begin
                        blend.blendStart <= 1'b1;
                        blend.upperInCacheA <= (tagA == upperRow);
                        state <= stretchPkg::decodeBlend;
                    end else begin
                        upstreamRequestRow <= missRow;
                        fillIntoB <= victimB;
                        state <= stretchPkg::decodeFetch;
                    end
                end
                stretchPkg::decodeFetch: begin
                    // The freshly claimed cache becomes the newer one
                    if (fillIntoB) begin
                        tagB <= upstreamRequestRow;
                        bIsOlder <= 1'b0;
                    end else begin
                        tagA <= upstreamRequestRow;
                        bIsOlder <= 1'b1;
                    end
                    state <= stretchPkg::decodeWait;
                end
                stretchPkg::decodeWait: begin
                    if (fillDone) begin
                        state <= stretchPkg::decodeCheck;
                    end
                end
                stretchPkg::decodeBlend: begin
                    if (blend.rowDone) begin
                        state <= stretchPkg::decodeIdle;
                    end
                end
                default: state <= stretchPkg::decodeIdle;
            endcase
        end
    end

    // Requests are handled one at a time
    noRequestWhileBusy: assert property (@(posedge scalerClock) disable iff (reset)
        busy |-> !rowRequest);

endmodule

/* logic/blendIf.sv */
// Blend control and weight bus between the row decoder and the blend pipeline

`timescale 1ns/1ns

interface blendIf;

    logic blendStart;
    stretchPkg::fractionT blendFraction;
    logic upperInCacheA;
    logic advance;
    logic weightsValid;
    stretchPkg::weightT upperRed;
    stretchPkg::weightT upperGreen;
    stretchPkg::weightT upperBlue;
    stretchPkg::weightT lowerRed;
    stretchPkg::weightT lowerGreen;
    stretchPkg::weightT lowerBlue;
    logic rowDone;

    modport decoder (output blendStart, blendFraction, upperInCacheA, input rowDone);

    modport execute (input blendStart, blendFraction, upperInCacheA, advance,
                     output weightsValid, upperRed, upperGreen, upperBlue,
                     lowerRed, lowerGreen, lowerBlue);

    modport result (output advance, rowDone,
                    input weightsValid, upperRed, upperGreen, upperBlue,
                    lowerRed, lowerGreen, lowerBlue);

endinterface

/* logic/stretchPkg.sv */
// Vector types and the decoder state encoding shared by the stretch filter

`include "stretch_config.svh"

package stretchPkg;

    // Red in the top 5 bits, green in the middle 6, blue in the low 5
    typedef logic [15:0] rgb565T;

    typedef logic [`STRETCH_ROW_BITS-1:0] rowT;
    typedef logic [`STRETCH_COLUMN_BITS-1:0] columnT;
    typedef logic [`STRETCH_FRACTION_BITS-1:0] fractionT;

    // One extra whole bit, so 64 stands for 1.0
    typedef logic [`STRETCH_FRACTION_BITS:0] scaleT;

    typedef logic [`STRETCH_ROW_BITS+`STRETCH_FRACTION_BITS-1:0] coordT;

    // A 6-bit color component times a coefficient
    typedef logic [`STRETCH_FRACTION_BITS+5:0] weightT;

    typedef enum logic [2:0] {
        decodeIdle,
        decodeMap,
        decodeCheck,
        decodeFetch,
        decodeWait,
        decodeBlend
    } decodeStateT;

endpackage

/* logic/stretch_config.svh */
// Width and line length macros for the vertical stretch filter

`ifndef STRETCH_CONFIG_SVH
`define STRETCH_CONFIG_SVH

// Width of a row number
`define STRETCH_ROW_BITS 11

// Fraction bits of the shrink factor and of a source position
`define STRETCH_FRACTION_BITS 6

// Pixels per row, with a column index wide enough to address them
`define STRETCH_LINE_WIDTH 16
`define STRETCH_COLUMN_BITS 4

`endif
